//--- verilog/f8_pkg.sv
package f8_pkg;

	typedef logic [7:0] byte_t;
	typedef logic [15:0] word_t;

	// opcode in byte 0, operands little-endian in bytes 1 and 2
	typedef logic [23:0] inst_t;

	typedef logic [2:0] flags_t;

	localparam int FLAG_C = 0;
	localparam int FLAG_Z = 1;
	localparam int FLAG_N = 2;

	localparam logic REG_X = 1'b0;
	localparam logic REG_Y = 1'b1;

	// unlisted encodings run as 1-byte nops
	typedef enum logic [7:0] {
		OP_NOP = 8'h00,

		// 2 bytes, immediate operand on xl
		OP_ADD_XL_IMMD = 8'h10,
		OP_ADC_XL_IMMD = 8'h11,
		OP_SUB_XL_IMMD = 8'h12,
		OP_SBC_XL_IMMD = 8'h13,
		OP_AND_XL_IMMD = 8'h14,
		OP_OR_XL_IMMD = 8'h15,
		OP_XOR_XL_IMMD = 8'h16,
		OP_CP_XL_IMMD = 8'h17,

		OP_LD_XL_IMMD = 8'h80,
		OP_LD_XL_DIR = 8'h81,
		OP_LD_XL_IY = 8'h82,
		OP_LD_DIR_XL = 8'h83,

		OP_JP_IMMD = 8'h90,
		OP_JR_D = 8'h91,
		OP_JRZ_D = 8'h92,
		OP_JRNZ_D = 8'h93,
		OP_JRC_D = 8'h94,
		OP_JRNC_D = 8'h95,

		OP_LDW_Y_IMMD = 8'hc0,
		OP_ADDW_Y_IMMD = 8'hc1,
		OP_LDW_DIR_Y = 8'hc3,

		OP_TRAP = 8'hff
	} opcode_t;

	typedef enum logic [3:0] {
		ALU_PASS,
		ALU_ADD,
		ALU_ADC,
		ALU_SUB,
		ALU_SBC,
		ALU_AND,
		ALU_OR,
		ALU_XOR,
		ALU_PASSW,
		ALU_ADDW
	} alu_op_t;

endpackage

//--- verilog/f8_alu.sv
`timescale 1ns/10ps

module f8_alu (
	input  f8_pkg::alu_op_t op,
	input  f8_pkg::word_t a,
	input  f8_pkg::word_t b,
	input  logic carry_in,
	output f8_pkg::word_t result,
	output f8_pkg::flags_t flags
);
	import f8_pkg::*;

	logic cin;
	logic sub;
	logic wide;
	byte_t b8;
	logic [8:0] sum8;
	logic [16:0] sum16;

	// plain add and sub start from a fixed carry, adc and sbc chain it
	always_comb
	begin
		case (op)
			ALU_ADD: cin = 1'b0;
			ALU_SUB: cin = 1'b1;
			default: cin = carry_in;
		endcase
	end

	// subtract is a + ~b + cin, carry set means no borrow
	assign sub = (op == ALU_SUB) || (op == ALU_SBC);
	assign b8 = sub ? ~b[7:0] : b[7:0];
	assign sum8 = {1'b0, a[7:0]} + {1'b0, b8} + {8'h00, cin};
	assign sum16 = {1'b0, a} + {1'b0, b};
	assign wide = (op == ALU_PASSW) || (op == ALU_ADDW);

	always_comb
	begin
		// high byte passes through on byte ops
		result = a;
		flags[FLAG_C] = 1'b0;
		case (op)
			ALU_ADD, ALU_ADC, ALU_SUB, ALU_SBC:
			begin
				result[7:0] = sum8[7:0];
				flags[FLAG_C] = sum8[8];
			end
			ALU_AND:
				result[7:0] = a[7:0] & b[7:0];
			ALU_OR:
				result[7:0] = a[7:0] | b[7:0];
			ALU_XOR:
				result[7:0] = a[7:0] ^ b[7:0];
			ALU_ADDW:
			begin
				result = sum16[15:0];
				flags[FLAG_C] = sum16[16];
			end
			default:
				result = a;
		endcase
		flags[FLAG_Z] = wide ? (result == 16'h0000) : (result[7:0] == 8'h00);
		flags[FLAG_N] = wide ? result[15] : result[7];
	end

endmodule

//--- verilog/f8_regfile.sv
`timescale 1ns/10ps

module f8_regfile (
	input  logic clk,
	input  logic addr,
	input  f8_pkg::word_t data,
	input  logic [1:0] write_en,
	output f8_pkg::word_t x,
	output f8_pkg::word_t y,
	output f8_pkg::word_t next_y
);
	import f8_pkg::*;

	word_t regs [2];
	logic y_sel;

	assign x = regs[REG_X];
	assign y = regs[REG_Y];

	// y after this clock, so a load through y can follow ldw y directly
	assign y_sel = (addr == REG_Y);
	assign next_y = {
		(y_sel && write_en[1]) ? data[15:8] : regs[REG_Y][15:8],
		(y_sel && write_en[0]) ? data[7:0] : regs[REG_Y][7:0]
	};

	always_ff @(posedge clk)
	begin
		if (write_en[0])
			regs[addr][7:0] <= data[7:0];
		if (write_en[1])
			regs[addr][15:8] <= data[15:8];
	end

endmodule

//--- verilog/f8_fetch.sv
`timescale 1ns/10ps

module f8_fetch #(
	parameter f8_pkg::word_t RESET_PC = 16'h4000
) (
	input  logic clk,
	input  logic reset,
	input  f8_pkg::inst_t iread_data,
	input  f8_pkg::flags_t next_flags,
	input  f8_pkg::word_t next_y,
	output f8_pkg::word_t iread_addr,
	output f8_pkg::word_t dread_addr,
	output f8_pkg::inst_t inst,
	output f8_pkg::word_t pc
);
	import f8_pkg::*;

	// address of the bytes now on iread_data
	word_t fetch_pc;
	word_t next_pc;
	word_t rel_target;
	opcode_t fetch_op;
	logic [1:0] len;
	logic taken;

	assign fetch_op = opcode_t'(iread_data[7:0]);
	assign rel_target = fetch_pc + {{8{iread_data[15]}}, iread_data[15:8]};

	always_comb
	begin
		case (fetch_op)
			OP_ADD_XL_IMMD, OP_ADC_XL_IMMD, OP_SUB_XL_IMMD, OP_SBC_XL_IMMD,
			OP_AND_XL_IMMD, OP_OR_XL_IMMD, OP_XOR_XL_IMMD, OP_CP_XL_IMMD,
			OP_LD_XL_IMMD, OP_JR_D, OP_JRZ_D, OP_JRNZ_D, OP_JRC_D, OP_JRNC_D:
				len = 2'd2;
			OP_LD_XL_DIR, OP_LD_DIR_XL, OP_JP_IMMD,
			OP_LDW_Y_IMMD, OP_ADDW_Y_IMMD, OP_LDW_DIR_Y:
				len = 2'd3;
			default:
				len = 2'd1;
		endcase
	end

	// flags as left by the instruction executing this cycle
	always_comb
	begin
		case (fetch_op)
			OP_JR_D: taken = 1'b1;
			OP_JRZ_D: taken = next_flags[FLAG_Z];
			OP_JRNZ_D: taken = !next_flags[FLAG_Z];
			OP_JRC_D: taken = next_flags[FLAG_C];
			OP_JRNC_D: taken = !next_flags[FLAG_C];
			default: taken = 1'b0;
		endcase
	end

	always_comb
	begin
		if (reset)
			next_pc = RESET_PC;
		else if (fetch_op == OP_JP_IMMD)
			next_pc = iread_data[23:8];
		else if (taken)
			next_pc = rel_target;
		else
			next_pc = fetch_pc + {14'd0, len};
	end

	assign iread_addr = next_pc;

	// data prefetch, read back while the load executes
	assign dread_addr = (fetch_op == OP_LD_XL_IY) ? next_y : iread_data[23:8];

	always_ff @(posedge clk)
	begin
		fetch_pc <= next_pc;
		pc <= fetch_pc;
		if (reset)
			inst <= {16'h0000, OP_NOP};
		else
			inst <= iread_data;
	end

endmodule

//--- verilog/f8_execute.sv
`timescale 1ns/10ps

module f8_execute (
	input  logic clk,
	input  logic reset,
	input  f8_pkg::inst_t inst,
	input  f8_pkg::word_t pc,
	input  f8_pkg::word_t x,
	input  f8_pkg::word_t y,
	input  f8_pkg::word_t dread_data,
	input  f8_pkg::word_t alu_result,
	input  f8_pkg::flags_t alu_flags,
	output f8_pkg::alu_op_t alu_op,
	output f8_pkg::word_t alu_a,
	output f8_pkg::word_t alu_b,
	output logic carry_in,
	output logic reg_addr,
	output f8_pkg::word_t reg_data,
	output logic [1:0] reg_en,
	output f8_pkg::flags_t next_flags,
	output f8_pkg::word_t dwrite_addr,
	output f8_pkg::word_t dwrite_data,
	output logic [1:0] dwrite_en,
	output logic trap
);
	import f8_pkg::*;

	opcode_t opcode;
	byte_t imm8;
	word_t imm16;
	flags_t flags;
	logic set_c;
	logic set_zn;

	assign opcode = opcode_t'(inst[7:0]);
	assign imm8 = inst[15:8];
	assign imm16 = inst[23:8];

	always_comb
	begin
		// idle ALU just carries the instruction address
		alu_op = ALU_PASSW;
		alu_a = pc;
		alu_b = imm16;
		reg_addr = REG_X;
		reg_en = 2'b00;
		dwrite_en = 2'b00;
		set_c = 1'b0;
		set_zn = 1'b0;
		case (opcode)
			OP_ADD_XL_IMMD, OP_ADC_XL_IMMD, OP_SUB_XL_IMMD, OP_SBC_XL_IMMD,
			OP_AND_XL_IMMD, OP_OR_XL_IMMD, OP_XOR_XL_IMMD, OP_CP_XL_IMMD:
			begin
				case (opcode)
					OP_ADD_XL_IMMD: alu_op = ALU_ADD;
					OP_ADC_XL_IMMD: alu_op = ALU_ADC;
					OP_SUB_XL_IMMD, OP_CP_XL_IMMD: alu_op = ALU_SUB;
					OP_SBC_XL_IMMD: alu_op = ALU_SBC;
					OP_AND_XL_IMMD: alu_op = ALU_AND;
					OP_OR_XL_IMMD: alu_op = ALU_OR;
					default: alu_op = ALU_XOR;
				endcase
				alu_a = x;
				alu_b = {8'h00, imm8};
				set_c = 1'b1;
				set_zn = 1'b1;
				// cp only compares
				if (opcode != OP_CP_XL_IMMD)
					reg_en = 2'b01;
			end
			OP_LD_XL_IMMD, OP_LD_XL_DIR, OP_LD_XL_IY:
			begin
				alu_op = ALU_PASS;
				alu_a = (opcode == OP_LD_XL_IMMD) ? {8'h00, imm8} : dread_data;
				reg_en = 2'b01;
				set_zn = 1'b1;
			end
			OP_LD_DIR_XL:
			begin
				alu_op = ALU_PASS;
				alu_a = x;
				dwrite_en = 2'b01;
			end
			OP_LDW_Y_IMMD, OP_ADDW_Y_IMMD:
			begin
				alu_op = (opcode == OP_ADDW_Y_IMMD) ? ALU_ADDW : ALU_PASSW;
				alu_a = (opcode == OP_ADDW_Y_IMMD) ? y : imm16;
				reg_addr = REG_Y;
				reg_en = 2'b11;
				set_c = (opcode == OP_ADDW_Y_IMMD);
				set_zn = 1'b1;
			end
			OP_LDW_DIR_Y:
			begin
				alu_a = y;
				dwrite_en = 2'b11;
			end
			default:
			begin
				alu_op = ALU_PASSW;
			end
		endcase
	end

	assign reg_data = alu_result;
	assign dwrite_data = alu_result;
	assign dwrite_addr = imm16;
	assign carry_in = flags[FLAG_C];
	assign trap = (opcode == OP_TRAP);

	always_comb
	begin
		next_flags = flags;
		if (set_c)
			next_flags[FLAG_C] = alu_flags[FLAG_C];
		if (set_zn)
		begin
			next_flags[FLAG_Z] = alu_flags[FLAG_Z];
			next_flags[FLAG_N] = alu_flags[FLAG_N];
		end
	end

	always_ff @(posedge clk)
	begin
		if (reset)
			flags <= '0;
		else
			flags <= next_flags;
	end

endmodule

//--- verilog/f8_core.sv
`timescale 1ns/10ps

module f8_core #(
	parameter f8_pkg::word_t RESET_PC = 16'h4000
) (
	input  logic clk,
	input  logic reset,
	output f8_pkg::word_t iread_addr,
	input  f8_pkg::inst_t iread_data,
	output f8_pkg::word_t dread_addr,
	input  f8_pkg::word_t dread_data,
	output f8_pkg::word_t dwrite_addr,
	output f8_pkg::word_t dwrite_data,
	output logic [1:0] dwrite_en,
	output logic trap
);
	import f8_pkg::*;

	inst_t inst;
	word_t pc;
	flags_t next_flags;
	word_t x;
	word_t y;
	word_t next_y;
	logic reg_addr;
	word_t reg_data;
	logic [1:0] reg_en;
	alu_op_t alu_op;
	word_t alu_a;
	word_t alu_b;
	logic carry_in;
	word_t alu_result;
	flags_t alu_flags;

	f8_fetch #(
		.RESET_PC(RESET_PC)
	) fetch (
		.clk(clk),
		.reset(reset),
		.iread_data(iread_data),
		.next_flags(next_flags),
		.next_y(next_y),
		.iread_addr(iread_addr),
		.dread_addr(dread_addr),
		.inst(inst),
		.pc(pc)
	);

	f8_execute execute (
		.clk(clk),
		.reset(reset),
		.inst(inst),
		.pc(pc),
		.x(x),
		.y(y),
		.dread_data(dread_data),
		.alu_result(alu_result),
		.alu_flags(alu_flags),
		.alu_op(alu_op),
		.alu_a(alu_a),
		.alu_b(alu_b),
		.carry_in(carry_in),
		.reg_addr(reg_addr),
		.reg_data(reg_data),
		.reg_en(reg_en),
		.next_flags(next_flags),
		.dwrite_addr(dwrite_addr),
		.dwrite_data(dwrite_data),
		.dwrite_en(dwrite_en),
		.trap(trap)
	);

	f8_regfile regfile (
		.clk(clk),
		.addr(reg_addr),
		.data(reg_data),
		.write_en(reg_en),
		.x(x),
		.y(y),
		.next_y(next_y)
	);

	f8_alu alu (
		.op(alu_op),
		.a(alu_a),
		.b(alu_b),
		.carry_in(carry_in),
		.result(alu_result),
		.flags(alu_flags)
	);

endmodule

//--- sim/f8_tb_mem.sv
`timescale 1ns/10ps

module f8_tb_mem (
	input  logic clk,
	input  f8_pkg::word_t iread_addr,
	output f8_pkg::inst_t iread_data,
	input  f8_pkg::word_t dread_addr,
	output f8_pkg::word_t dread_data,
	input  f8_pkg::word_t dwrite_addr,
	input  f8_pkg::word_t dwrite_data,
	input  logic [1:0] dwrite_en
);
	import f8_pkg::*;

	byte_t bytes [0:65535];

	initial
	begin
		iread_data = '0;
		dread_data = '0;
	end

	// both read ports return what was addressed on the previous clock
	always @(posedge clk)
	begin
		iread_data <= {bytes[iread_addr + 16'd2], bytes[iread_addr + 16'd1], bytes[iread_addr]};
		dread_data <= {bytes[dread_addr + 16'd1], bytes[dread_addr]};
		if (dwrite_en[0])
			bytes[dwrite_addr] <= dwrite_data[7:0];
		if (dwrite_en[1])
			bytes[dwrite_addr + 16'd1] <= dwrite_data[15:8];
	end

	// empty memory decodes as nops
	task clear();
		for (int a = 0; a < 65536; a++)
			bytes[a] = 8'h00;
	endtask

	task load_byte(input word_t addr, input byte_t value);
		bytes[addr] = value;
	endtask

endmodule

//--- sim/f8_core_chk.sv
`timescale 1ns/10ps

module f8_core_chk #(
	parameter f8_pkg::word_t RESET_PC = 16'h4000
) (
	input  logic clk,
	input  logic reset,
	input  f8_pkg::word_t iread_addr,
	input  logic [1:0] dwrite_en,
	input  logic trap
);
	int unsigned assert_failures = 0;

	// inst holds a nop from the first reset clock on
	property quiet_in_reset;
		@(posedge clk) reset ##1 reset |-> (dwrite_en == 2'b00) && !trap;
	endproperty

	property pc_held_in_reset;
		@(posedge clk) reset |-> iread_addr == RESET_PC;
	endproperty

	property no_high_byte_only_store;
		@(posedge clk) disable iff (reset) dwrite_en != 2'b10;
	endproperty

	quiet_in_reset_a: assert property (quiet_in_reset)
	else
	begin
		assert_failures++;
		$error("store or trap active while reset is held");
	end

	pc_held_in_reset_a: assert property (pc_held_in_reset)
	else
	begin
		assert_failures++;
		$error("fetch address differs from the reset pc during reset");
	end

	no_high_byte_only_store_a: assert property (no_high_byte_only_store)
	else
	begin
		assert_failures++;
		$error("store enable 10 is not a legal byte lane pattern");
	end

endmodule

//--- sim/tb_f8_core.sv
`timescale 1ns/10ps

module tb_f8_core;
	import f8_pkg::*;

	localparam word_t RESET_PC = 16'h4000;
	localparam int RESET_CYCLES = 16;
	localparam int TRAP_TIMEOUT = 200;
	localparam int ALU_CASES = 22;
	localparam int WIDE_CASES = 3;

	typedef struct packed {
		opcode_t op;
		byte_t a;
		byte_t b;
		logic cin;
		byte_t xl;
		logic c;
		logic z;
	} alu_case_t;

	logic clk = 1'b0;
	logic reset;
	word_t iread_addr;
	inst_t iread_data;
	word_t dread_addr;
	word_t dread_data;
	word_t dwrite_addr;
	word_t dwrite_data;
	logic [1:0] dwrite_en;
	logic trap;

	int error_count = 0;
	int check_count = 0;
	int trap_count = 0;
	string prog_name = "";
	word_t asm_pc;

	word_t got_addr [$];
	logic [1:0] got_en [$];
	word_t got_data [$];
	word_t exp_addr [$];
	logic [1:0] exp_en [$];
	word_t exp_data [$];

	// op, a, b, carry before the op, stored xl, C, Z
	alu_case_t alu_table [ALU_CASES] = '{
		'{OP_ADD_XL_IMMD, 8'h12, 8'h34, 1'b0, 8'h46, 1'b0, 1'b0},
		'{OP_ADD_XL_IMMD, 8'hf0, 8'h20, 1'b0, 8'h10, 1'b1, 1'b0},
		'{OP_ADD_XL_IMMD, 8'h80, 8'h80, 1'b1, 8'h00, 1'b1, 1'b1},
		'{OP_ADC_XL_IMMD, 8'h12, 8'h34, 1'b1, 8'h47, 1'b0, 1'b0},
		'{OP_ADC_XL_IMMD, 8'hff, 8'h00, 1'b1, 8'h00, 1'b1, 1'b1},
		'{OP_ADC_XL_IMMD, 8'h7f, 8'h80, 1'b0, 8'hff, 1'b0, 1'b0},
		'{OP_SUB_XL_IMMD, 8'h50, 8'h20, 1'b0, 8'h30, 1'b1, 1'b0},
		'{OP_SUB_XL_IMMD, 8'h20, 8'h50, 1'b1, 8'hd0, 1'b0, 1'b0},
		'{OP_SUB_XL_IMMD, 8'h44, 8'h44, 1'b0, 8'h00, 1'b1, 1'b1},
		'{OP_SBC_XL_IMMD, 8'h50, 8'h20, 1'b0, 8'h2f, 1'b1, 1'b0},
		'{OP_SBC_XL_IMMD, 8'h50, 8'h20, 1'b1, 8'h30, 1'b1, 1'b0},
		'{OP_SBC_XL_IMMD, 8'h00, 8'h00, 1'b0, 8'hff, 1'b0, 1'b0},
		'{OP_SBC_XL_IMMD, 8'h01, 8'h00, 1'b0, 8'h00, 1'b1, 1'b1},
		'{OP_AND_XL_IMMD, 8'hf0, 8'h3c, 1'b1, 8'h30, 1'b0, 1'b0},
		'{OP_AND_XL_IMMD, 8'h0f, 8'hf0, 1'b0, 8'h00, 1'b0, 1'b1},
		'{OP_OR_XL_IMMD, 8'h00, 8'h00, 1'b1, 8'h00, 1'b0, 1'b1},
		'{OP_OR_XL_IMMD, 8'ha5, 8'h5a, 1'b0, 8'hff, 1'b0, 1'b0},
		'{OP_XOR_XL_IMMD, 8'h5a, 8'h5a, 1'b1, 8'h00, 1'b0, 1'b1},
		'{OP_XOR_XL_IMMD, 8'h0f, 8'hff, 1'b0, 8'hf0, 1'b0, 1'b0},
		'{OP_CP_XL_IMMD, 8'h40, 8'h40, 1'b0, 8'h40, 1'b1, 1'b1},
		'{OP_CP_XL_IMMD, 8'h10, 8'h20, 1'b1, 8'h10, 1'b0, 1'b0},
		'{OP_CP_XL_IMMD, 8'h20, 8'h10, 1'b0, 8'h20, 1'b1, 1'b0}
	};

	word_t wide_a [WIDE_CASES] = '{16'h1234, 16'h8000, 16'h00ff};
	word_t wide_b [WIDE_CASES] = '{16'hf00f, 16'h8000, 16'h0001};

	always #5 clk = ~clk;

	f8_core #(
		.RESET_PC(RESET_PC)
	) UUT (
		.clk(clk),
		.reset(reset),
		.iread_addr(iread_addr),
		.iread_data(iread_data),
		.dread_addr(dread_addr),
		.dread_data(dread_data),
		.dwrite_addr(dwrite_addr),
		.dwrite_data(dwrite_data),
		.dwrite_en(dwrite_en),
		.trap(trap)
	);

	f8_tb_mem mem (
		.clk(clk),
		.iread_addr(iread_addr),
		.iread_data(iread_data),
		.dread_addr(dread_addr),
		.dread_data(dread_data),
		.dwrite_addr(dwrite_addr),
		.dwrite_data(dwrite_data),
		.dwrite_en(dwrite_en)
	);

	bind f8_core f8_core_chk #(
		.RESET_PC(RESET_PC)
	) core_chk (
		.clk(clk),
		.reset(reset),
		.iread_addr(iread_addr),
		.dwrite_en(dwrite_en),
		.trap(trap)
	);

	// store and trap monitor, sampled mid cycle
	always @(negedge clk)
	begin
		if (!reset)
		begin
			if (dwrite_en != 2'b00)
			begin
				if (trap_count != 0)
				begin
					error_count++;
					$display("%s: a store to %h happened after the trap", prog_name, dwrite_addr);
				end
				got_addr.push_back(dwrite_addr);
				got_en.push_back(dwrite_en);
				got_data.push_back(dwrite_data & {{8{dwrite_en[1]}}, 8'hff});
			end
			if (trap)
				trap_count++;
		end
	end

	task automatic check_value(input string name, input logic [31:0] got,
		input logic [31:0] expected);
		check_count++;
		if (got !== expected)
		begin
			error_count++;
			$display("FAILED %s in %s: got %h, expected %h", name, prog_name, got, expected);
		end
	endtask

	task automatic org(input word_t addr);
		asm_pc = addr;
	endtask

	task automatic emit(input byte_t value);
		mem.load_byte(asm_pc, value);
		asm_pc = asm_pc + 16'd1;
	endtask

	task automatic emit_op(input opcode_t op);
		emit(op);
	endtask

	task automatic emit_imm8(input opcode_t op, input byte_t value);
		emit(op);
		emit(value);
	endtask

	task automatic emit_imm16(input opcode_t op, input word_t value);
		emit(op);
		emit(value[7:0]);
		emit(value[15:8]);
	endtask

	task automatic expect_store(input word_t addr, input logic [1:0] en, input word_t data);
		exp_addr.push_back(addr);
		exp_en.push_back(en);
		exp_data.push_back(data & {{8{en[1]}}, 8'hff});
	endtask

	// reset goes up here and stays up while the program is assembled
	task automatic begin_program(input string name);
		@(posedge clk);
		#1;
		reset = 1'b1;
		prog_name = name;
		mem.clear();
		got_addr.delete();
		got_en.delete();
		got_data.delete();
		exp_addr.delete();
		exp_en.delete();
		exp_data.delete();
		trap_count = 0;
		org(RESET_PC);
	endtask

	task automatic compare_stores();
		int n;
		check_value("store count", got_addr.size(), exp_addr.size());
		n = (got_addr.size() < exp_addr.size()) ? got_addr.size() : exp_addr.size();
		for (int i = 0; i < n; i++)
		begin
			check_value("dwrite_addr", got_addr[i], exp_addr[i]);
			check_value("dwrite_en", got_en[i], exp_en[i]);
			check_value("dwrite_data", got_data[i], exp_data[i]);
		end
	endtask

	task automatic run_program();
		int cycles;
		logic done;
		for (int i = 0; i < RESET_CYCLES; i++)
		begin
			@(negedge clk);
			check_value("iread_addr", iread_addr, RESET_PC);
			if (i > 0)
			begin
				check_value("dwrite_en", dwrite_en, 2'b00);
				check_value("trap", trap, 1'b0);
			end
		end
		@(posedge clk);
		#1;
		reset = 1'b0;
		cycles = 0;
		done = 1'b0;
		while (!done && cycles < TRAP_TIMEOUT)
		begin
			@(negedge clk);
			cycles++;
			done = (trap === 1'b1);
		end
		if (!done)
		begin
			error_count++;
			$display("%s: no trap within %0d cycles", prog_name, TRAP_TIMEOUT);
		end
		// a few more cycles to catch a second trap or a late store
		repeat (8) @(negedge clk);
		@(posedge clk);
		check_value("trap pulses", trap_count, 1);
		compare_stores();
	endtask

	task automatic run_alu_case(input alu_case_t row, input int index);
		begin_program($sformatf("alu row %0d", index));
		emit_imm8(OP_LD_XL_IMMD, row.a);
		// cp with 0 always carries, add of 0 never does
		if (row.cin)
			emit_imm8(OP_CP_XL_IMMD, 8'h00);
		else
			emit_imm8(OP_ADD_XL_IMMD, 8'h00);
		emit_imm8(row.op, row.b);
		emit_imm16(OP_LD_DIR_XL, 16'h0100);
		// z first, the marker load clobbers z but keeps c
		emit_imm8(OP_JRNZ_D, 8'h07);
		emit_imm8(OP_LD_XL_IMMD, 8'h02);
		emit_imm16(OP_LD_DIR_XL, 16'h0102);
		emit_imm8(OP_JRNC_D, 8'h07);
		emit_imm8(OP_LD_XL_IMMD, 8'h01);
		emit_imm16(OP_LD_DIR_XL, 16'h0101);
		emit_op(OP_TRAP);
		expect_store(16'h0100, 2'b01, {8'h00, row.xl});
		if (row.z)
			expect_store(16'h0102, 2'b01, 16'h0002);
		if (row.c)
			expect_store(16'h0101, 2'b01, 16'h0001);
		run_program();
	endtask

	task automatic run_wide_add(input word_t a, input word_t b, input int index);
		begin_program($sformatf("addw case %0d", index));
		emit_imm16(OP_LDW_Y_IMMD, a);
		emit_imm16(OP_ADDW_Y_IMMD, b);
		emit_imm16(OP_LDW_DIR_Y, 16'h0200);
		emit_op(OP_TRAP);
		expect_store(16'h0200, 2'b11, word_t'(a + b));
		run_program();
	endtask

	task automatic run_load_case();
		begin_program("loads");
		mem.load_byte(16'h0300, 8'h5c);
		mem.load_byte(16'h0321, 8'ha7);
		emit_imm16(OP_LD_XL_DIR, 16'h0300);
		emit_imm16(OP_LD_DIR_XL, 16'h0110);
		// stale y points at the other byte
		emit_imm16(OP_LDW_Y_IMMD, 16'h0300);
		emit_imm16(OP_LDW_Y_IMMD, 16'h0321);
		emit_op(OP_LD_XL_IY);
		emit_imm16(OP_LD_DIR_XL, 16'h0111);
		emit_op(OP_TRAP);
		expect_store(16'h0110, 2'b01, 16'h005c);
		expect_store(16'h0111, 2'b01, 16'h00a7);
		run_program();
	endtask

	task automatic run_jump_case();
		begin_program("jumps");
		emit_imm8(OP_LD_XL_IMMD, 8'h11);
		emit_imm16(OP_JP_IMMD, 16'h4020);
		emit_imm16(OP_LD_DIR_XL, 16'h0100);
		emit_op(OP_TRAP);
		org(16'h4010);
		emit_imm16(OP_LD_DIR_XL, 16'h0102);
		emit_imm8(OP_JR_D, 8'h20);
		emit_imm16(OP_LD_DIR_XL, 16'h0103);
		emit_op(OP_TRAP);
		// backward to 4010
		org(16'h4020);
		emit_imm8(OP_JR_D, 8'hf0);
		emit_imm16(OP_LD_DIR_XL, 16'h0101);
		emit_op(OP_TRAP);
		org(16'h4033);
		emit_imm16(OP_LD_DIR_XL, 16'h0104);
		emit_op(OP_TRAP);
		expect_store(16'h0102, 2'b01, 16'h0011);
		expect_store(16'h0104, 2'b01, 16'h0011);
		run_program();
	endtask

	initial
	begin
		int total;
		reset = 1'b1;
		for (int i = 0; i < ALU_CASES; i++)
			run_alu_case(alu_table[i], i);
		for (int i = 0; i < WIDE_CASES; i++)
			run_wide_add(wide_a[i], wide_b[i], i);
		run_load_case();
		run_jump_case();
		total = error_count + UUT.core_chk.assert_failures;
		$display("checks %0d, errors %0d, assertion failures %0d",
			check_count, error_count, UUT.core_chk.assert_failures);
		if (total == 0)
			$display("RESULT: PASS");
		else
			$display("RESULT: FAIL");
		$finish;
	end

endmodule

//--- filelist.f
verilog/f8_pkg.sv
verilog/f8_alu.sv
verilog/f8_regfile.sv
verilog/f8_fetch.sv
verilog/f8_execute.sv
verilog/f8_core.sv
sim/f8_tb_mem.sv
sim/f8_core_chk.sv
sim/tb_f8_core.sv

//--- Bender.yml
package:
  name: f8_core

sources:
  # rtl
  - files:
      - verilog/f8_pkg.sv
      - verilog/f8_alu.sv
      - verilog/f8_regfile.sv
      - verilog/f8_fetch.sv
      - verilog/f8_execute.sv
      - verilog/f8_core.sv
  # sim
  - target: simulation
    files:
      - sim/f8_tb_mem.sv
      - sim/f8_core_chk.sv
      - sim/tb_f8_core.sv
